/* sources.f */
src/rename_cfg_pkg.sv
src/rename_apb_pkg.sv
src/rename_ifs.sv
src/map_table.sv
src/free_list.sv
src/checkpoint_array.sv
src/rename_ctrl.sv
src/rename_top.sv
verif/rename_tb.sv

/* verif/rename_tb.sv */
// ----------------------------------------------------------
// testbench for the rename block: clock, reset, APB tasks,
// reference model of map, free list and checkpoints,
// directed tests, compare tasks and timeout
// ----------------------------------------------------------

module rename_tb import rename_cfg_pkg::*, rename_apb_pkg::*;;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int AR_COUNT   = DEF_AR_COUNT;
    localparam int PR_COUNT   = DEF_PR_COUNT;
    localparam int CKPT_COUNT = DEF_CKPT_COUNT;
    localparam int FREE_MAX   = PR_COUNT - AR_COUNT;
    localparam int N_ALLOC    = 8;
    localparam int N_FREE     = 4;
    localparam int N_REFILL   = 8;
    localparam int N_SPEC     = 6;

    // transfers per test, sweeps cost AR_COUNT transfers
    localparam int XFER_RESET = 1 + 2 * 4;
    localparam int XFER_ALLOC = 2 * N_ALLOC + 1;
    localparam int XFER_FREE  = N_FREE + 2 * (FREE_MAX - N_ALLOC + N_FREE) + 3 + AR_COUNT;
    localparam int XFER_CKPT  = N_REFILL + 2 + 2 * N_SPEC + 2 + AR_COUNT + 2;
    localparam int XFER_ERR   = FREE_MAX + 12;
    localparam int XFERS      = XFER_RESET + XFER_ALLOC + XFER_FREE + XFER_CKPT + XFER_ERR;
    localparam int TIMEOUT_CYCLES = 4 * XFERS * 2 + 16;

    logic           CLK = 1'b0;
    logic           nRST = 1'b0;
    logic [3:0]     paddr = '0;
    logic           psel = 1'b0;
    logic           penable = 1'b0;
    logic           pwrite = 1'b0;
    logic [31:0]    pwdata = '0;
    logic [31:0]    prdata;
    logic           pready;
    logic           pslverr;

    int             cycle_count = 0;
    logic [31:0]    rng_state = 32'h3b317022;

    // ------------------------------------------------------------
    // reference model

    int                     map_model[AR_COUNT];
    // every entry ever queued, head index moves forward or rewinds
    int                     fl_log[$];
    int                     fl_head;
    // old mappings, candidates to free later
    int                     pool[$];
    int                     saved_map[CKPT_COUNT][AR_COUNT];
    int                     saved_head[CKPT_COUNT];
    int                     saved_pool_len[CKPT_COUNT];
    logic [CKPT_COUNT-1:0]  valid_model;
    logic [7:0]             exp_src1;
    logic [7:0]             exp_src2;
    logic [7:0]             exp_new;
    logic [7:0]             exp_old;

    always #20 CLK = ~CLK;

    rename_top #(
        .AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT), .CKPT_COUNT(CKPT_COUNT)
    ) rename_top_i (
        .CLK(CLK), .nRST(nRST),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr)
    );

    // ------------------------------------------------------------
    // failure, compares, random numbers

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    always @(posedge CLK) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            abort_run("timeout: the tests did not finish within the cycle limit");
        end
    end

    task automatic compare_result(input logic [31:0] got, input logic [7:0] e_src1,
                                  input logic [7:0] e_src2, input logic [7:0] e_new,
                                  input logic [7:0] e_old);
        logic [31:0] exp;
        exp = {e_src1, e_src2, e_new, e_old};
        if (got !== exp) begin
            abort_run($sformatf("error prdata RESULT got %h exp %h", got, exp));
        end
    endtask

    task automatic compare_status(input logic [31:0] got, input logic [7:0] e_count,
                                  input logic [CKPT_COUNT-1:0] e_mask);
        logic [31:0] exp;
        exp = '0;
        exp[STAT_COUNT_LSB +: 8] = e_count;
        exp[STAT_MASK_LSB +: CKPT_COUNT] = e_mask;
        if (got !== exp) begin
            abort_run($sformatf("error prdata STATUS got %h exp %h", got, exp));
        end
    endtask

    task automatic compare_err(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error pslverr got %h exp %h", got, exp));
        end
    endtask

    task automatic compare_ready(input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error pready got %h exp %h", got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic int rand_ar();
        rng_state = xorshift32(rng_state);
        return int'(rng_state % AR_COUNT);
    endfunction

    function automatic int free_count();
        return fl_log.size() - fl_head;
    endfunction

    // ------------------------------------------------------------
    // APB transfers, setup then access, no idle between

    task automatic apb_write(input logic [3:0] addr, input logic [31:0] data,
                             output logic err);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        // setup phase, not ready yet
        @(negedge CLK);
        compare_ready(pready, 1'b0);
        @(posedge CLK);
        penable <= 1'b1;
        // sample mid access phase
        @(negedge CLK);
        while (pready !== 1'b1) @(negedge CLK);
        err = pslverr;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(input logic [3:0] addr, output logic [31:0] data);
        @(posedge CLK);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        // setup phase, not ready yet
        @(negedge CLK);
        compare_ready(pready, 1'b0);
        @(posedge CLK);
        penable <= 1'b1;
        @(negedge CLK);
        while (pready !== 1'b1) @(negedge CLK);
        data = prdata;
        @(posedge CLK);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic logic [31:0] rename_word(input rename_op_e op, input logic has_dest,
                                                input int dest, input int s1, input int s2);
        cmd_word_u w;
        w = '0;
        w.ren.opcode   = op;
        w.ren.has_dest = has_dest;
        w.ren.dest_ar  = 8'(dest);
        w.ren.src1_ar  = 8'(s1);
        w.ren.src2_ar  = 8'(s2);
        return w;
    endfunction

    function automatic logic [31:0] ckpt_word(input rename_op_e op, input int slot);
        cmd_word_u w;
        w = '0;
        w.ckpt.opcode = op;
        w.ckpt.slot   = 8'(slot);
        return w;
    endfunction

    // ------------------------------------------------------------
    // command checks against the model

    task automatic rename_check(input logic has_dest, input int dest, input int s1,
                                input int s2);
        logic           err;
        logic           exp_err;
        logic [31:0]    res;
        exp_err = has_dest && (free_count() == 0);
        apb_write(ADDR_CMD, rename_word(OP_RENAME, has_dest, dest, s1, s2), err);
        compare_err(err, exp_err);
        // on error RESULT keeps the last good rename
        if (!exp_err) begin
            // sources see the map before this rename
            exp_src1 = 8'(map_model[s1]);
            exp_src2 = 8'(map_model[s2]);
            exp_new  = '0;
            exp_old  = '0;
            if (has_dest) begin
                exp_new = 8'(fl_log[fl_head]);
                exp_old = 8'(map_model[dest]);
                pool.push_back(map_model[dest]);
                map_model[dest] = fl_log[fl_head];
                fl_head++;
            end
        end
        apb_read(ADDR_RESULT, res);
        compare_result(res, exp_src1, exp_src2, exp_new, exp_old);
    endtask

    task automatic free_check(input int pr);
        logic err;
        logic exp_err;
        exp_err = (free_count() >= FREE_MAX) || (pr >= PR_COUNT);
        apb_write(ADDR_CMD, rename_word(OP_FREE, 1'b0, pr, 0, 0), err);
        compare_err(err, exp_err);
        if (!exp_err) begin
            fl_log.push_back(pr);
        end
    endtask

    task automatic save_check(input int slot);
        logic err;
        logic exp_err;
        exp_err = slot >= CKPT_COUNT;
        apb_write(ADDR_CMD, ckpt_word(OP_SAVE, slot), err);
        compare_err(err, exp_err);
        if (!exp_err) begin
            for (int ar = 0; ar < AR_COUNT; ar++) begin
                saved_map[slot][ar] = map_model[ar];
            end
            saved_head[slot]     = fl_head;
            saved_pool_len[slot] = pool.size();
            valid_model[slot]    = 1'b1;
        end
    endtask

    task automatic restore_check(input int slot);
        logic err;
        logic exp_err;
        exp_err = (slot >= CKPT_COUNT) || !valid_model[slot % CKPT_COUNT];
        apb_write(ADDR_CMD, ckpt_word(OP_RESTORE, slot), err);
        compare_err(err, exp_err);
        if (!exp_err) begin
            for (int ar = 0; ar < AR_COUNT; ar++) begin
                map_model[ar] = saved_map[slot][ar];
            end
            fl_head = saved_head[slot];
            // drop old mappings from the squashed renames
            while (pool.size() > saved_pool_len[slot]) void'(pool.pop_back());
        end
    endtask

    task automatic status_check();
        logic [31:0] st;
        apb_read(ADDR_STATUS, st);
        compare_status(st, 8'(free_count()), valid_model);
    endtask

    // lookup of every AR, two per rename
    task automatic map_sweep();
        for (int ar = 0; ar < AR_COUNT; ar += 2) begin
            rename_check(1'b0, 0, ar, ar + 1);
        end
    endtask

    // ------------------------------------------------------------
    // directed tests

    task automatic reset_state();
        status_check();
        repeat (4) rename_check(1'b0, 0, rand_ar(), rand_ar());
    endtask

    task automatic alloc_order();
        repeat (N_ALLOC) rename_check(1'b1, rand_ar(), rand_ar(), rand_ar());
        status_check();
    endtask

    task automatic freed_regs();
        repeat (N_FREE) free_check(pool.pop_front());
        // drain the list, freed PRs come out last
        while (free_count() > 0) rename_check(1'b1, rand_ar(), rand_ar(), rand_ar());
        rename_check(1'b1, rand_ar(), rand_ar(), rand_ar());
        status_check();
        map_sweep();
    endtask

    task automatic ckpt_restore();
        repeat (N_REFILL) free_check(pool.pop_front());
        save_check(1);
        status_check();
        repeat (N_SPEC) rename_check(1'b1, rand_ar(), rand_ar(), rand_ar());
        restore_check(1);
        status_check();
        map_sweep();
        // allocation resumes at the saved head
        rename_check(1'b1, rand_ar(), rand_ar(), rand_ar());
    endtask

    task automatic error_cases();
        restore_check(0);
        restore_check(2);
        restore_check(3);
        status_check();
        save_check(CKPT_COUNT);
        restore_check(CKPT_COUNT);
        status_check();
        restore_check(200);
        status_check();
        while (free_count() < FREE_MAX) begin
            if (pool.size() == 0) begin
                abort_run("no freeable register left to fill the free list");
            end
            free_check(pool.pop_front());
        end
        status_check();
        free_check(PR_COUNT - 1);
        status_check();
    endtask

    // ------------------------------------------------------------
    // main sequence

    initial begin
        for (int ar = 0; ar < AR_COUNT; ar++) begin
            map_model[ar] = ar;
        end
        for (int pr = AR_COUNT; pr < PR_COUNT; pr++) begin
            fl_log.push_back(pr);
        end
        fl_head     = 0;
        valid_model = '0;
        exp_src1    = '0;
        exp_src2    = '0;
        exp_new     = '0;
        exp_old     = '0;
        repeat (16) @(posedge CLK);
        nRST <= 1'b1;
        reset_state();
        alloc_order();
        freed_regs();
        ckpt_restore();
        error_cases();
        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* src/rename_top.sv */
// ----------------------------------------------------------
// rename block top: APB ports, interface instances and the
// map table, free list, checkpoint array and controller
// ----------------------------------------------------------

module rename_top import rename_cfg_pkg::*; #(
    parameter int AR_COUNT   = DEF_AR_COUNT,
    parameter int PR_COUNT   = DEF_PR_COUNT,
    parameter int CKPT_COUNT = DEF_CKPT_COUNT
) (
    input  logic        CLK,
    input  logic        nRST,
    input  logic [3:0]  paddr,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);

    // checkpoint strobes between controller and slots
    logic                   save_strobe;
    logic                   restore_strobe;
    logic [7:0]             slot;
    logic [CKPT_COUNT-1:0]  slot_valid;

    map_if  #(.AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT)) map_bus ();
    free_if #(.PR_COUNT(PR_COUNT))                      free_bus ();

    map_table #(.AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT)) map_table_i (
        .CLK(CLK), .nRST(nRST), .m(map_bus.tbl)
    );

    free_list #(.AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT)) free_list_i (
        .CLK(CLK), .nRST(nRST), .f(free_bus.queue)
    );

    checkpoint_array #(
        .AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT), .CKPT_COUNT(CKPT_COUNT)
    ) checkpoint_array_i (
        .CLK(CLK), .nRST(nRST), .m(map_bus.ckpt), .f(free_bus.ckpt),
        .save_strobe(save_strobe), .restore_strobe(restore_strobe),
        .slot(slot), .slot_valid(slot_valid)
    );

    rename_ctrl #(
        .AR_COUNT(AR_COUNT), .PR_COUNT(PR_COUNT), .CKPT_COUNT(CKPT_COUNT)
    ) rename_ctrl_i (
        .CLK(CLK), .nRST(nRST),
        .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
        .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
        .m(map_bus.ctrl), .f(free_bus.ctrl),
        .save_strobe(save_strobe), .restore_strobe(restore_strobe),
        .slot(slot), .slot_valid(slot_valid)
    );

endmodule

/* src/rename_ctrl.sv */
// ----------------------------------------------------------
// APB slave and command decode for the rename block
// error checks, datapath strobes, RESULT and STATUS
// ----------------------------------------------------------

module rename_ctrl import rename_cfg_pkg::*, rename_apb_pkg::*; #(
    parameter int AR_COUNT   = DEF_AR_COUNT,
    parameter int PR_COUNT   = DEF_PR_COUNT,
    parameter int CKPT_COUNT = DEF_CKPT_COUNT
) (
    input  logic                    CLK,
    input  logic                    nRST,
    // apb
    input  logic [3:0]              paddr,
    input  logic                    psel,
    input  logic                    penable,
    input  logic                    pwrite,
    input  logic [31:0]             pwdata,
    output logic [31:0]             prdata,
    output logic                    pready,
    output logic                    pslverr,
    // datapath
    map_if.ctrl                     m,
    free_if.ctrl                    f,
    output logic                    save_strobe,
    output logic                    restore_strobe,
    output logic [7:0]              slot,
    input  logic [CKPT_COUNT-1:0]   slot_valid
);

    localparam int ARW = idx_w(AR_COUNT);
    localparam int PRW = idx_w(PR_COUNT);
    localparam int SLW = idx_w(CKPT_COUNT);

    cmd_word_u      cmd;
    logic           wr_cmd;
    logic           rd_access;
    logic           cmd_err;
    logic           go;
    logic           src_ok;
    logic           dest_ok;
    logic           free_ok;
    logic           slot_ok;
    logic [31:0]    result_d;
    logic [31:0]    result_q;
    logic [31:0]    status;

    // ------------------------------------------------------------
    // apb handshake, no wait states

    assign pready    = psel & penable;
    assign wr_cmd    = pready & pwrite & (paddr == ADDR_CMD);
    assign rd_access = pready & ~pwrite;
    assign cmd       = pwdata;

    // ------------------------------------------------------------
    // decode and checks

    assign src_ok  = (int'(cmd.ren.src1_ar) < AR_COUNT) && (int'(cmd.ren.src2_ar) < AR_COUNT);
    assign dest_ok = int'(cmd.ren.dest_ar) < AR_COUNT;
    // free_pr shares the dest byte
    assign free_ok = int'(cmd.ren.dest_ar) < PR_COUNT;
    assign slot_ok = int'(cmd.ckpt.slot) < CKPT_COUNT;

    always_comb begin
        case (cmd.ren.opcode)
            OP_RENAME:  cmd_err = !src_ok || (cmd.ren.has_dest && (!dest_ok || f.empty));
            OP_FREE:    cmd_err = !free_ok || f.full;
            OP_SAVE:    cmd_err = !slot_ok;
            OP_RESTORE: cmd_err = !slot_ok || !slot_valid[cmd.ckpt.slot[SLW-1:0]];
            default:    cmd_err = 1'b1;
        endcase
    end

    assign pslverr = wr_cmd & cmd_err;
    // erroring commands touch nothing
    assign go      = wr_cmd & ~cmd_err;

    // ------------------------------------------------------------
    // datapath strobes

    // port 2 looks up the dest for its old mapping
    assign m.rd_ar[0] = cmd.ren.src1_ar[ARW-1:0];
    assign m.rd_ar[1] = cmd.ren.src2_ar[ARW-1:0];
    assign m.rd_ar[2] = cmd.ren.dest_ar[ARW-1:0];

    // allocate: new PR straight off the free head
    assign m.wr_valid = go & (cmd.ren.opcode == OP_RENAME) & cmd.ren.has_dest;
    assign m.wr_ar    = cmd.ren.dest_ar[ARW-1:0];
    assign m.wr_pr    = f.head_pr;
    assign f.pop      = m.wr_valid;

    assign f.push     = go & (cmd.ren.opcode == OP_FREE);
    assign f.push_pr  = cmd.ren.dest_ar[PRW-1:0];

    assign save_strobe    = go & (cmd.ckpt.opcode == OP_SAVE);
    assign restore_strobe = go & (cmd.ckpt.opcode == OP_RESTORE);
    assign slot           = cmd.ckpt.slot;

    // ------------------------------------------------------------
    // result and status

    // dest bytes read zero for a rename without a destination
    always_comb begin
        result_d = '0;
        result_d[RES_SRC1_LSB +: 8] = 8'(m.rd_pr[0]);
        result_d[RES_SRC2_LSB +: 8] = 8'(m.rd_pr[1]);
        if (cmd.ren.has_dest) begin
            result_d[RES_NEW_LSB +: 8] = 8'(f.head_pr);
            result_d[RES_OLD_LSB +: 8] = 8'(m.rd_pr[2]);
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            result_q <= '0;
        end else if (go && (cmd.ren.opcode == OP_RENAME)) begin
            result_q <= result_d;
        end
    end

    always_comb begin
        status = '0;
        status[STAT_COUNT_LSB +: 8] = 8'(f.count);
        status[STAT_MASK_LSB +: 8]  = 8'(slot_valid);
    end

    always_comb begin
        prdata = '0;
        if (rd_access) begin
            case (paddr)
                ADDR_RESULT: prdata = result_q;
                ADDR_STATUS: prdata = status;
                default:     prdata = '0;
            endcase
        end
    end

    // ------------------------------------------------------------
    // checks

    a_err_in_access: assert property (
        @(posedge CLK) disable iff (!nRST) pslverr |-> pready
    );

endmodule

/* src/checkpoint_array.sv */
// ----------------------------------------------------------
// checkpoint slots: map snapshot and free-list head per slot
// ----------------------------------------------------------

module checkpoint_array import rename_cfg_pkg::*; #(
    parameter int AR_COUNT   = DEF_AR_COUNT,
    parameter int PR_COUNT   = DEF_PR_COUNT,
    parameter int CKPT_COUNT = DEF_CKPT_COUNT
) (
    input  logic                    CLK,
    input  logic                    nRST,
    map_if.ckpt                     m,
    free_if.ckpt                    f,
    input  logic                    save_strobe,
    input  logic                    restore_strobe,
    input  logic [7:0]              slot,
    output logic [CKPT_COUNT-1:0]   slot_valid
);

    localparam int PRW  = idx_w(PR_COUNT);
    localparam int PTRW = ptr_w(PR_COUNT);
    localparam int SLW  = idx_w(CKPT_COUNT);

    logic [CKPT_COUNT-1:0][AR_COUNT-1:0][PRW-1:0]   map_store;
    logic [CKPT_COUNT-1:0][PTRW-1:0]                head_store;
    logic [CKPT_COUNT-1:0]                          valid_q;
    logic [SLW-1:0]                                 idx;

    // slot range is checked upstream
    assign idx        = slot[SLW-1:0];
    assign slot_valid = valid_q;

    // restore is same cycle, so the edge that ends the access loads it
    assign m.restore_valid  = restore_strobe;
    assign m.restore_map    = map_store[idx];
    assign f.restore_valid  = restore_strobe;
    assign f.restore_head   = head_store[idx];

    // snapshot contents
    always_ff @(posedge CLK) begin
        if (save_strobe) begin
            map_store[idx]  <= m.save_map;
            head_store[idx] <= f.head_ptr;
        end
    end

    // valid bits, a restore keeps the slot for reuse
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (save_strobe) begin
            valid_q[idx] <= 1'b1;
        end
    end

endmodule

/* src/free_list.sv */
// ----------------------------------------------------------
// free physical register queue, circular with wrap-bit
// pointers, head save and restore for checkpoints
// ----------------------------------------------------------

module free_list import rename_cfg_pkg::*; #(
    parameter int AR_COUNT = DEF_AR_COUNT,
    parameter int PR_COUNT = DEF_PR_COUNT
) (
    input logic     CLK,
    input logic     nRST,
    free_if.queue   f
);

    localparam int PRW  = idx_w(PR_COUNT);
    localparam int PTRW = ptr_w(PR_COUNT);
    // all non-architectural registers free
    localparam int FREE_MAX = PR_COUNT - AR_COUNT;

    // ------------------------------------------------------------
    // storage and pointers

    logic [PR_COUNT-1:0][PRW-1:0]   mem;
    logic [PTRW-1:0]                head_q;
    logic [PTRW-1:0]                tail_q;

    // wrap bit makes tail - head the occupancy
    assign f.count    = tail_q - head_q;
    assign f.empty    = (f.count == '0);
    assign f.full     = (int'(f.count) >= FREE_MAX);
    assign f.head_pr  = mem[head_q[PRW-1:0]];
    assign f.head_ptr = head_q;

    // ------------------------------------------------------------
    // update

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            // preload PR AR_COUNT .. PR_COUNT-1, ascending
            for (int i = 0; i < PR_COUNT; i++) begin
                mem[i] <= (i < FREE_MAX) ? PRW'(AR_COUNT + i) : '0;
            end
            head_q <= '0;
            tail_q <= PTRW'(FREE_MAX);
        end else begin
            if (f.push) begin
                mem[tail_q[PRW-1:0]] <= f.push_pr;
                tail_q <= tail_q + 1'b1;
            end
            // rewinding the head hands back everything popped since the save
            if (f.restore_valid) begin
                head_q <= f.restore_head;
            end else if (f.pop) begin
                head_q <= head_q + 1'b1;
            end
        end
    end

    // ------------------------------------------------------------
    // checks

    a_no_pop_empty: assert property (
        @(posedge CLK) disable iff (!nRST) f.pop |-> !f.empty
    );

    a_no_push_full: assert property (
        @(posedge CLK) disable iff (!nRST) f.push |-> !f.full
    );

endmodule

/* src/map_table.sv */
// ----------------------------------------------------------
// architectural to physical register map
// three read ports, one write port, save and restore
// ----------------------------------------------------------

module map_table import rename_cfg_pkg::*; #(
    parameter int AR_COUNT = DEF_AR_COUNT,
    parameter int PR_COUNT = DEF_PR_COUNT
) (
    input logic     CLK,
    input logic     nRST,
    map_if.tbl      m
);

    localparam int PRW = idx_w(PR_COUNT);

    // ------------------------------------------------------------
    // state

    logic [AR_COUNT-1:0][PRW-1:0] map_q;
    // map with the pending write folded in
    logic [AR_COUNT-1:0][PRW-1:0] map_upd;

    // ------------------------------------------------------------
    // reads and write merge

    always_comb begin
        for (int p = 0; p < 3; p++) begin
            m.rd_pr[p] = map_q[m.rd_ar[p]];
        end
    end

    always_comb begin
        map_upd = map_q;
        if (m.wr_valid) begin
            map_upd[m.wr_ar] = m.wr_pr;
        end
    end

    // snapshot already sees this cycle's write
    assign m.save_map = map_upd;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            // identity: AR n lives in PR n
            for (int ar = 0; ar < AR_COUNT; ar++) begin
                map_q[ar] <= PRW'(ar);
            end
        end else if (m.restore_valid) begin
            // restore wins over any write
            map_q <= m.restore_map;
        end else begin
            map_q <= map_upd;
        end
    end

    // ------------------------------------------------------------
    // checks

    a_wr_in_range: assert property (
        @(posedge CLK) disable iff (!nRST)
        m.wr_valid |-> (int'(m.wr_ar) < AR_COUNT)
    );

endmodule

/* src/rename_ifs.sv */
// ----------------------------------------------------------
// map_if: map table reads, write, save and restore paths
// free_if: free-list pop/push, status and head restore
// ----------------------------------------------------------

interface map_if import rename_cfg_pkg::*; #(
    parameter int AR_COUNT = DEF_AR_COUNT,
    parameter int PR_COUNT = DEF_PR_COUNT
);
    localparam int ARW = idx_w(AR_COUNT);
    localparam int PRW = idx_w(PR_COUNT);

    // ports 0,1 for sources, port 2 for the old dest
    logic [2:0][ARW-1:0]            rd_ar;
    logic [2:0][PRW-1:0]            rd_pr;

    // single write port
    logic                           wr_valid;
    logic [ARW-1:0]                 wr_ar;
    logic [PRW-1:0]                 wr_pr;

    // snapshot out, restore in
    logic [AR_COUNT-1:0][PRW-1:0]   save_map;
    logic                           restore_valid;
    logic [AR_COUNT-1:0][PRW-1:0]   restore_map;

    modport tbl (
        input  rd_ar, wr_valid, wr_ar, wr_pr, restore_valid, restore_map,
        output rd_pr, save_map
    );
    modport ctrl (output rd_ar, wr_valid, wr_ar, wr_pr, input rd_pr);
    modport ckpt (input save_map, output restore_valid, restore_map);
endinterface

interface free_if import rename_cfg_pkg::*; #(
    parameter int PR_COUNT = DEF_PR_COUNT
);
    localparam int PRW  = idx_w(PR_COUNT);
    localparam int PTRW = ptr_w(PR_COUNT);

    logic               pop;
    logic               push;
    logic [PRW-1:0]     push_pr;

    logic [PRW-1:0]     head_pr;
    logic               empty;
    logic               full;
    logic [PTRW-1:0]    count;
    logic [PTRW-1:0]    head_ptr;

    logic               restore_valid;
    logic [PTRW-1:0]    restore_head;

    modport queue (
        input  pop, push, push_pr, restore_valid, restore_head,
        output head_pr, empty, full, count, head_ptr
    );
    modport ctrl (output pop, push, push_pr, input head_pr, empty, full, count);
    modport ckpt (input head_ptr, output restore_valid, restore_head);
endinterface

/* src/rename_apb_pkg.sv */
// ----------------------------------------------------------
// APB register map, command opcodes, the command word union
// and the bit positions of the RESULT and STATUS fields
// ----------------------------------------------------------

package rename_apb_pkg;

    // byte addresses in the 4-bit APB window
    localparam logic [3:0] ADDR_CMD    = 4'h0;
    localparam logic [3:0] ADDR_RESULT = 4'h4;
    localparam logic [3:0] ADDR_STATUS = 4'h8;

    // opcode in bits 31:30 of every command
    typedef enum logic [1:0] {
        OP_RENAME  = 2'd0,
        OP_FREE    = 2'd1,
        OP_SAVE    = 2'd2,
        OP_RESTORE = 2'd3
    } rename_op_e;

    // rename view, also used by OP_FREE
    // free_pr sits in the dest_ar byte
    typedef struct packed {
        rename_op_e  opcode;
        logic        has_dest;
        logic [4:0]  rsvd;
        logic [7:0]  dest_ar;
        logic [7:0]  src1_ar;
        logic [7:0]  src2_ar;
    } rename_cmd_t;

    // checkpoint view, for OP_SAVE and OP_RESTORE
    typedef struct packed {
        rename_op_e  opcode;
        logic [21:0] rsvd;
        logic [7:0]  slot;
    } ckpt_cmd_t;

    typedef union packed {
        rename_cmd_t ren;
        ckpt_cmd_t   ckpt;
    } cmd_word_u;

    // RESULT bytes, high to low: src1, src2, new dest, old dest
    localparam int RES_SRC1_LSB = 24;
    localparam int RES_SRC2_LSB = 16;
    localparam int RES_NEW_LSB  = 8;
    localparam int RES_OLD_LSB  = 0;

    // STATUS: free count in the low byte, slot valid mask above it
    localparam int STAT_COUNT_LSB = 0;
    localparam int STAT_MASK_LSB  = 8;

endpackage

/* src/rename_cfg_pkg.sv */
// ----------------------------------------------------------
// default sizes of the architectural and physical register
// spaces and of the checkpoint store, plus width helpers
// ----------------------------------------------------------

package rename_cfg_pkg;

    // architectural registers, identity mapped at reset
    localparam int DEF_AR_COUNT = 32;

    // physical registers, a power of two for the free-list pointers
    localparam int DEF_PR_COUNT = 64;

    // checkpoint slots
    localparam int DEF_CKPT_COUNT = 4;

    // bits to index n entries, never zero
    function automatic int idx_w(input int n);
        return (n > 1) ? $clog2(n) : 1;
    endfunction

    // queue pointer width: index plus one wrap bit
    function automatic int ptr_w(input int n);
        return idx_w(n) + 1;
    endfunction

endpackage
